/* design/tcm_pkg.sv */
// All windows are word aligned and must not overlap; sizes are in bytes, END addresses inclusive
package tcm_pkg;

    // ------------------------------------------------------------------
    // Bus widths
    // ------------------------------------------------------------------
    localparam int XLEN   = 32;
    localparam int STRB_W = XLEN / 8;

    // ------------------------------------------------------------------
    // Memory map
    // ------------------------------------------------------------------
    // Instruction TCM, 4 KiB
    localparam logic [XLEN-1:0] ITCM_BASE     = 32'h0000_0000;
    localparam logic [XLEN-1:0] ITCM_SIZE     = 32'h0000_1000;

    // Data TCM, 4 KiB
    localparam logic [XLEN-1:0] DTCM_BASE     = 32'h0001_0000;
    localparam logic [XLEN-1:0] DTCM_SIZE     = 32'h0000_1000;

    // External data bus window
    localparam logic [XLEN-1:0] EXT_DATA_BASE = 32'h1000_0000;
    localparam logic [XLEN-1:0] EXT_DATA_END  = 32'h1000_FFFF;

    // ------------------------------------------------------------------
    // Bus structs
    // ------------------------------------------------------------------
    // Load/store style request, held by the requester until ack
    typedef struct packed {
        logic              req;
        logic              we;
        logic [XLEN-1:0]   addr;
        logic [XLEN-1:0]   wdata;
        logic [STRB_W-1:0] strb;
    } mem_req_t;

    // Response, ack is a single cycle pulse
    typedef struct packed {
        logic            ack;
        logic            error;
        logic [XLEN-1:0] rdata;
    } mem_ack_t;

    // Instruction fetch, read only
    typedef struct packed {
        logic            req;
        logic [XLEN-1:0] addr;
    } fetch_req_t;

    // ------------------------------------------------------------------
    // State encodings
    // ------------------------------------------------------------------
    // Demux outstanding transaction
    typedef enum logic [1:0] {
        ROUTE_IDLE,
        ROUTE_CH1,
        ROUTE_CH2,
        ROUTE_ERR
    } route_e;

    // Arbiter response owed next cycle
    typedef enum logic [1:0] {
        GRANT_NONE,
        GRANT_CORE,
        GRANT_EXT
    } grant_e;

endpackage

/* design/tcm_bank.sv */
// Single port RAM with one cycle read latency; no reset on contents, addresses must lie in the window
`timescale 1ns/1ns

module tcm_bank #(
    parameter logic [tcm_pkg::XLEN-1:0] BASE  = tcm_pkg::ITCM_BASE,
    parameter int                       DEPTH = 1024
) (
    input  logic                     clk_i,
    input  logic                     en_i,
    input  tcm_pkg::mem_req_t        req_i,
    output logic [tcm_pkg::XLEN-1:0] rdata_o
);

    import tcm_pkg::*;

    localparam int AW = $clog2(DEPTH);

    logic [XLEN-1:0] mem [DEPTH];
    logic [XLEN-1:0] offset;
    logic [AW-1:0]   word_idx;

    // Byte offset from the window base, then word index
    assign offset   = req_i.addr - BASE;
    assign word_idx = offset[AW+1:2];

    // ------------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (en_i) begin
            if (req_i.we) begin
                // Only the strobed bytes change
                for (int b = 0; b < STRB_W; b++) begin
                    if (req_i.strb[b]) begin
                        mem[word_idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
                    end
                end
            end else begin
                rdata_o <= mem[word_idx];
            end
        end
    end

    // ------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------
    // Any enabled access has to land inside BASE .. BASE + DEPTH words;
    // catches fetches outside the ITCM that the top level does not decode
    a_addr_in_window: assert property (
        @(posedge clk_i) en_i |-> (offset < DEPTH * STRB_W)
    ) else $error("tcm_bank: access at %h outside window base %h", req_i.addr, BASE);

endmodule

/* design/tcm_arbiter.sv */
// External side has fixed priority and requesters must hold req until their one cycle ack
`timescale 1ns/1ns

module tcm_arbiter (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  tcm_pkg::mem_req_t        core_req_i,
    output tcm_pkg::mem_ack_t        core_ack_o,
    input  tcm_pkg::mem_req_t        ext_req_i,
    output tcm_pkg::mem_ack_t        ext_ack_o,
    output logic                     bank_en_o,
    output tcm_pkg::mem_req_t        bank_req_o,
    input  logic [tcm_pkg::XLEN-1:0] bank_rdata_i
);

    import tcm_pkg::*;

    grant_e grant_d;
    grant_e pending_q;
    logic   ext_ok;
    logic   core_ok;

    // A side whose ack is due this cycle still holds req and is masked
    assign ext_ok  = ext_req_i.req && (pending_q != GRANT_EXT);
    assign core_ok = core_req_i.req && (pending_q != GRANT_CORE);

    // ------------------------------------------------------------------
    // Grant
    // ------------------------------------------------------------------
    always_comb begin
        if (ext_ok) begin
            grant_d = GRANT_EXT;
        end else if (core_ok) begin
            grant_d = GRANT_CORE;
        end else begin
            grant_d = GRANT_NONE;
        end
    end

    assign bank_en_o = (grant_d != GRANT_NONE);

    // Winner's fields go to the bank
    always_comb begin
        if (grant_d == GRANT_EXT) begin
            bank_req_o = ext_req_i;
        end else begin
            bank_req_o = core_req_i;
        end
        bank_req_o.req = bank_en_o;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pending_q <= GRANT_NONE;
        end else begin
            pending_q <= grant_d;
        end
    end

    // ------------------------------------------------------------------
    // Response one cycle after the grant
    // ------------------------------------------------------------------
    always_comb begin
        core_ack_o       = '0;
        ext_ack_o        = '0;
        core_ack_o.rdata = bank_rdata_i;
        ext_ack_o.rdata  = bank_rdata_i;
        core_ack_o.ack   = (pending_q == GRANT_CORE);
        ext_ack_o.ack    = (pending_q == GRANT_EXT);
    end

    // ------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------
    // Ack answers last cycle's grant to a request that is still held
    a_core_ack_granted: assert property (
        @(posedge clk_i) disable iff (rst_i)
        core_ack_o.ack |-> $past(grant_d == GRANT_CORE) && core_req_i.req
    ) else $error("tcm_arbiter: core ack without grant");

    a_ext_ack_granted: assert property (
        @(posedge clk_i) disable iff (rst_i)
        ext_ack_o.ack |-> $past(grant_d == GRANT_EXT) && ext_req_i.req
    ) else $error("tcm_arbiter: ext ack without grant");

endmodule

/* design/port_demux.sv */
// Two window decoder with inclusive END bounds; unmatched requests get an error ack after one cycle
`timescale 1ns/1ns

module port_demux #(
    parameter logic [tcm_pkg::XLEN-1:0] CH1_BASE = tcm_pkg::DTCM_BASE,
    parameter logic [tcm_pkg::XLEN-1:0] CH1_END  = tcm_pkg::DTCM_BASE + tcm_pkg::DTCM_SIZE - 1,
    parameter logic [tcm_pkg::XLEN-1:0] CH2_BASE = tcm_pkg::EXT_DATA_BASE,
    parameter logic [tcm_pkg::XLEN-1:0] CH2_END  = tcm_pkg::EXT_DATA_END
) (
    input  logic              clk_i,
    input  logic              rst_i,
    input  tcm_pkg::mem_req_t up_req_i,
    output tcm_pkg::mem_ack_t up_ack_o,
    output tcm_pkg::mem_req_t ch1_req_o,
    input  tcm_pkg::mem_ack_t ch1_ack_i,
    output tcm_pkg::mem_req_t ch2_req_o,
    input  tcm_pkg::mem_ack_t ch2_ack_i
);

    import tcm_pkg::*;

    route_e route_q;
    route_e route_dec;
    route_e route_sel;
    logic   hit_ch1;
    logic   hit_ch2;

    // ------------------------------------------------------------------
    // Address decode
    // ------------------------------------------------------------------
    assign hit_ch1 = (up_req_i.addr >= CH1_BASE) && (up_req_i.addr <= CH1_END);
    assign hit_ch2 = (up_req_i.addr >= CH2_BASE) && (up_req_i.addr <= CH2_END);

    always_comb begin
        if (hit_ch1) begin
            route_dec = ROUTE_CH1;
        end else if (hit_ch2) begin
            route_dec = ROUTE_CH2;
        end else begin
            route_dec = ROUTE_ERR;
        end
    end

    // Fresh decode only when nothing is outstanding
    assign route_sel = (route_q == ROUTE_IDLE) ? route_dec : route_q;

    // ------------------------------------------------------------------
    // Outstanding transaction
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            route_q <= ROUTE_IDLE;
        end else if (up_ack_o.ack) begin
            route_q <= ROUTE_IDLE;
        end else if ((route_q == ROUTE_IDLE) && up_req_i.req) begin
            route_q <= route_dec;
        end
    end

    // ------------------------------------------------------------------
    // Request steering
    // ------------------------------------------------------------------
    always_comb begin
        ch1_req_o = '0;
        ch2_req_o = '0;
        case (route_sel)
            ROUTE_CH1: ch1_req_o = up_req_i;
            ROUTE_CH2: ch2_req_o = up_req_i;
            default: begin
                // Error route forwards nothing
                ch1_req_o = '0;
                ch2_req_o = '0;
            end
        endcase
    end

    // ------------------------------------------------------------------
    // Response return
    // ------------------------------------------------------------------
    always_comb begin
        up_ack_o = '0;
        case (route_q)
            ROUTE_CH1: up_ack_o = ch1_ack_i;
            ROUTE_CH2: up_ack_o = ch2_ack_i;
            ROUTE_ERR: begin
                up_ack_o.ack   = 1'b1;
                up_ack_o.error = 1'b1;
            end
            default: up_ack_o = '0;
        endcase
    end

    // ------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------
    // Downstream may only answer a request this demux has routed
    a_no_stray_ack: assert property (
        @(posedge clk_i) disable iff (rst_i)
        (route_q == ROUTE_IDLE) |-> !ch1_ack_i.ack && !ch2_ack_i.ack
    ) else $error("port_demux: channel ack with no outstanding request");

endmodule

/* design/tcm_subsystem.sv */
// Single clock TCM subsystem; fetch addresses are not decoded and must stay inside the ITCM
`timescale 1ns/1ns

module tcm_subsystem (
    input  logic                clk_i,
    input  logic                rst_i,
    input  tcm_pkg::fetch_req_t fetch_i,
    output tcm_pkg::mem_ack_t   fetch_ack_o,
    input  tcm_pkg::mem_req_t   lsu_req_i,
    output tcm_pkg::mem_ack_t   lsu_ack_o,
    input  tcm_pkg::mem_req_t   ext_req_i,
    output tcm_pkg::mem_ack_t   ext_ack_o,
    output tcm_pkg::mem_req_t   data_req_o,
    input  tcm_pkg::mem_ack_t   data_ack_i
);

    import tcm_pkg::*;

    // Inclusive window ends and bank depths in words
    localparam logic [XLEN-1:0] ITCM_END   = ITCM_BASE + ITCM_SIZE - 1;
    localparam logic [XLEN-1:0] DTCM_END   = DTCM_BASE + DTCM_SIZE - 1;
    localparam int              ITCM_DEPTH = ITCM_SIZE / STRB_W;
    localparam int              DTCM_DEPTH = DTCM_SIZE / STRB_W;

    mem_req_t        fetch_req;
    mem_req_t        lsu_dtcm_req;
    mem_ack_t        lsu_dtcm_ack;
    mem_req_t        ext_itcm_req;
    mem_ack_t        ext_itcm_ack;
    mem_req_t        ext_dtcm_req;
    mem_ack_t        ext_dtcm_ack;

    logic            itcm_en;
    mem_req_t        itcm_req;
    logic [XLEN-1:0] itcm_rdata;
    logic            dtcm_en;
    mem_req_t        dtcm_req;
    logic [XLEN-1:0] dtcm_rdata;

    // Fetch seen as a plain word read
    assign fetch_req.req   = fetch_i.req;
    assign fetch_req.we    = 1'b0;
    assign fetch_req.addr  = fetch_i.addr;
    assign fetch_req.wdata = '0;
    assign fetch_req.strb  = '0;

    // ------------------------------------------------------------------
    // Address decoders
    // ------------------------------------------------------------------
    // Load/store: DTCM or external data bus
    port_demux #(
        .CH1_BASE ( DTCM_BASE     ),
        .CH1_END  ( DTCM_END      ),
        .CH2_BASE ( EXT_DATA_BASE ),
        .CH2_END  ( EXT_DATA_END  )
    ) u_lsu_demux (
        .clk_i     ( clk_i        ),
        .rst_i     ( rst_i        ),
        .up_req_i  ( lsu_req_i    ),
        .up_ack_o  ( lsu_ack_o    ),
        .ch1_req_o ( lsu_dtcm_req ),
        .ch1_ack_i ( lsu_dtcm_ack ),
        .ch2_req_o ( data_req_o   ),
        .ch2_ack_i ( data_ack_i   )
    );

    // Loader/debugger: ITCM or DTCM
    port_demux #(
        .CH1_BASE ( ITCM_BASE ),
        .CH1_END  ( ITCM_END  ),
        .CH2_BASE ( DTCM_BASE ),
        .CH2_END  ( DTCM_END  )
    ) u_ext_demux (
        .clk_i     ( clk_i        ),
        .rst_i     ( rst_i        ),
        .up_req_i  ( ext_req_i    ),
        .up_ack_o  ( ext_ack_o    ),
        .ch1_req_o ( ext_itcm_req ),
        .ch1_ack_i ( ext_itcm_ack ),
        .ch2_req_o ( ext_dtcm_req ),
        .ch2_ack_i ( ext_dtcm_ack )
    );

    // ------------------------------------------------------------------
    // Instruction TCM
    // ------------------------------------------------------------------
    tcm_arbiter u_itcm_arb (
        .clk_i        ( clk_i        ),
        .rst_i        ( rst_i        ),
        .core_req_i   ( fetch_req    ),
        .core_ack_o   ( fetch_ack_o  ),
        .ext_req_i    ( ext_itcm_req ),
        .ext_ack_o    ( ext_itcm_ack ),
        .bank_en_o    ( itcm_en      ),
        .bank_req_o   ( itcm_req     ),
        .bank_rdata_i ( itcm_rdata   )
    );

    tcm_bank #(
        .BASE  ( ITCM_BASE  ),
        .DEPTH ( ITCM_DEPTH )
    ) u_itcm (
        .clk_i   ( clk_i      ),
        .en_i    ( itcm_en    ),
        .req_i   ( itcm_req   ),
        .rdata_o ( itcm_rdata )
    );

    // ------------------------------------------------------------------
    // Data TCM
    // ------------------------------------------------------------------
    tcm_arbiter u_dtcm_arb (
        .clk_i        ( clk_i        ),
        .rst_i        ( rst_i        ),
        .core_req_i   ( lsu_dtcm_req ),
        .core_ack_o   ( lsu_dtcm_ack ),
        .ext_req_i    ( ext_dtcm_req ),
        .ext_ack_o    ( ext_dtcm_ack ),
        .bank_en_o    ( dtcm_en      ),
        .bank_req_o   ( dtcm_req     ),
        .bank_rdata_i ( dtcm_rdata   )
    );

    tcm_bank #(
        .BASE  ( DTCM_BASE  ),
        .DEPTH ( DTCM_DEPTH )
    ) u_dtcm (
        .clk_i   ( clk_i      ),
        .en_i    ( dtcm_en    ),
        .req_i   ( dtcm_req   ),
        .rdata_o ( dtcm_rdata )
    );

endmodule

/* dv/tcm_subsystem_tb.sv */
// Checks run as concurrent assertions; DTCM and ITCM reads only touch words written earlier
`timescale 1ns/1ns

module tcm_subsystem_tb;

    import tcm_pkg::*;

    typedef struct packed {
        logic            read;
        logic            err;
        logic [XLEN-1:0] rdata;
    } expect_t;

    // About 500 cycles of traffic, four times that as margin
    localparam int              MAX_CYCLES = 2000;
    localparam logic [XLEN-1:0] EXT_SIZE   = EXT_DATA_END - EXT_DATA_BASE + 1;

    logic       clk_i = 1'b0;
    logic       rst_i;
    fetch_req_t fetch_i;
    mem_ack_t   fetch_ack_o;
    mem_req_t   lsu_req_i;
    mem_ack_t   lsu_ack_o;
    mem_req_t   ext_req_i;
    mem_ack_t   ext_ack_o;
    mem_req_t   data_req_o;
    mem_ack_t   data_ack_i = '0;

    expect_t         lsu_exp;
    expect_t         ext_exp;
    expect_t         fetch_exp;
    logic [XLEN-1:0] tcm_shadow [logic [XLEN-1:0]];
    logic [XLEN-1:0] ext_shadow [logic [XLEN-1:0]];
    logic            started;
    int              errors = 0;
    int              cycles = 0;
    logic            slave_busy;
    logic [2:0]      slave_cnt;
    logic [31:0]     slave_rnd;
    logic [XLEN-1:0] slave_key;
    logic            lsu_in_dtcm;
    logic            lsu_in_ext;
    logic            lsu_out;
    logic            ext_in_dtcm;
    logic            ext_out;

    always #20 clk_i = ~clk_i;

    tcm_subsystem UUT (
        .clk_i       ( clk_i       ),
        .rst_i       ( rst_i       ),
        .fetch_i     ( fetch_i     ),
        .fetch_ack_o ( fetch_ack_o ),
        .lsu_req_i   ( lsu_req_i   ),
        .lsu_ack_o   ( lsu_ack_o   ),
        .ext_req_i   ( ext_req_i   ),
        .ext_ack_o   ( ext_ack_o   ),
        .data_req_o  ( data_req_o  ),
        .data_ack_i  ( data_ack_i  )
    );

    // ------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------
    function automatic logic in_window(input logic [XLEN-1:0] addr,
                                       input logic [XLEN-1:0] base,
                                       input logic [XLEN-1:0] size);
        return (addr - base) < size;
    endfunction

    function automatic logic [XLEN-1:0] merge_bytes(input logic [XLEN-1:0] old_w,
                                                    input logic [XLEN-1:0] new_w,
                                                    input logic [STRB_W-1:0] strb);
        logic [XLEN-1:0] res;
        res = old_w;
        for (int b = 0; b < STRB_W; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    // Top 4 KiB of the external window is a hole that answers with error
    function automatic logic slave_error(input logic [XLEN-1:0] addr);
        return addr[15:12] == 4'hF;
    endfunction

    function automatic logic [XLEN-1:0] slave_word(input logic [XLEN-1:0] key);
        if (ext_shadow.exists(key)) begin
            return ext_shadow[key];
        end
        return {~key[15:0], key[15:0]};
    endfunction

    assign lsu_in_dtcm = in_window(lsu_req_i.addr, DTCM_BASE, DTCM_SIZE);
    assign lsu_in_ext  = in_window(lsu_req_i.addr, EXT_DATA_BASE, EXT_SIZE);
    assign lsu_out     = !lsu_in_dtcm && !lsu_in_ext;
    assign ext_in_dtcm = in_window(ext_req_i.addr, DTCM_BASE, DTCM_SIZE);
    assign ext_out     = !ext_in_dtcm && !in_window(ext_req_i.addr, ITCM_BASE, ITCM_SIZE);

    // ------------------------------------------------------------------
    // External data slave, 1 to 4 cycles of wait after it sees req
    // ------------------------------------------------------------------
    always @(posedge clk_i) begin
        if (rst_i) begin
            data_ack_i <= '0;
            slave_busy <= 1'b0;
            slave_cnt  <= '0;
        end else if (data_ack_i.ack) begin
            data_ack_i <= '0;
        end else if (!slave_busy) begin
            if (data_req_o.req) begin
                slave_rnd  = $urandom_range(4, 1);
                slave_busy <= 1'b1;
                slave_cnt  <= slave_rnd[2:0];
            end
        end else if (slave_cnt > 3'd1) begin
            slave_cnt <= slave_cnt - 3'd1;
        end else begin
            slave_key  = {data_req_o.addr[XLEN-1:2], 2'b00};
            slave_busy <= 1'b0;
            data_ack_i <= '{ack: 1'b1, error: slave_error(slave_key),
                            rdata: slave_error(slave_key) ? '0 : slave_word(slave_key)};
            if (data_req_o.we && !slave_error(slave_key)) begin
                ext_shadow[slave_key] = merge_bytes(slave_word(slave_key), data_req_o.wdata,
                                                    data_req_o.strb);
            end
        end
    end

    // ------------------------------------------------------------------
    // Requester tasks
    // ------------------------------------------------------------------
    task automatic note_failure(input string msg);
        errors++;
        $display("[FAIL] %0t: %s", $time, msg);
    endtask

    // Load/store or debugger transaction; shadow follows acknowledged TCM writes
    task automatic access(input logic on_ext, input logic we, input logic [XLEN-1:0] addr,
                          input logic [XLEN-1:0] wdata, input logic [STRB_W-1:0] strb);
        mem_req_t        txn;
        expect_t         exp;
        logic [XLEN-1:0] key;
        logic            tcm;
        key = {addr[XLEN-1:2], 2'b00};
        txn = '{req: 1'b1, we: we, addr: addr, wdata: wdata, strb: strb};
        tcm = in_window(addr, DTCM_BASE, DTCM_SIZE)
              || (on_ext && in_window(addr, ITCM_BASE, ITCM_SIZE));
        exp.read  = !we;
        exp.err   = !tcm;
        exp.rdata = tcm_shadow.exists(key) ? tcm_shadow[key] : '0;
        if (!on_ext && in_window(addr, EXT_DATA_BASE, EXT_SIZE)) begin
            exp.err   = slave_error(key);
            exp.rdata = slave_word(key);
        end
        @(posedge clk_i);
        started <= 1'b1;
        if (on_ext) begin
            ext_req_i <= txn;
            ext_exp   <= exp;
        end else begin
            lsu_req_i <= txn;
            lsu_exp   <= exp;
        end
        do @(posedge clk_i); while (on_ext ? !ext_ack_o.ack : !lsu_ack_o.ack);
        if (on_ext) begin
            ext_req_i.req <= 1'b0;
        end else begin
            lsu_req_i.req <= 1'b0;
        end
        if (we && tcm) begin
            tcm_shadow[key] = merge_bytes(exp.rdata, wdata, strb);
        end
    endtask

    task automatic fetch_word(input logic [XLEN-1:0] addr);
        expect_t exp;
        exp = '{read: 1'b1, err: 1'b0, rdata: tcm_shadow[{addr[XLEN-1:2], 2'b00}]};
        @(posedge clk_i);
        started   <= 1'b1;
        fetch_i   <= '{req: 1'b1, addr: addr};
        fetch_exp <= exp;
        do @(posedge clk_i); while (!fetch_ack_o.ack);
        fetch_i.req <= 1'b0;
    endtask

    // ------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------
    a_quiet_after_reset: assert property (@(posedge clk_i) disable iff (rst_i)
        !started |-> !lsu_ack_o.ack && !ext_ack_o.ack && !fetch_ack_o.ack && !data_req_o.req)
        else note_failure("ack or external bus request before any request");

    a_fetch_resp: assert property (@(posedge clk_i) disable iff (rst_i)
        fetch_ack_o.ack |-> !fetch_ack_o.error && fetch_ack_o.rdata == fetch_exp.rdata)
        else note_failure("fetch data differs from shadow memory");

    a_lsu_resp: assert property (@(posedge clk_i) disable iff (rst_i)
        lsu_ack_o.ack |-> lsu_ack_o.error == lsu_exp.err
            && (lsu_exp.err || !lsu_exp.read || lsu_ack_o.rdata == lsu_exp.rdata))
        else note_failure("load/store response differs from model");

    a_ext_resp: assert property (@(posedge clk_i) disable iff (rst_i)
        ext_ack_o.ack |-> ext_ack_o.error == ext_exp.err
            && (ext_exp.err || !ext_exp.read || ext_ack_o.rdata == ext_exp.rdata))
        else note_failure("debugger response differs from model");

    a_fetch_latency: assert property (@(posedge clk_i) disable iff (rst_i)
        $rose(fetch_i.req) && !ext_req_i.req |=> fetch_ack_o.ack)
        else note_failure("uncontended fetch not acknowledged after one cycle");

    a_lsu_dtcm_latency: assert property (@(posedge clk_i) disable iff (rst_i)
        $rose(lsu_req_i.req) && lsu_in_dtcm && !ext_req_i.req |=> lsu_ack_o.ack)
        else note_failure("uncontended DTCM access not acknowledged after one cycle");

    a_ext_tcm_latency: assert property (@(posedge clk_i) disable iff (rst_i)
        $rose(ext_req_i.req) && !ext_out |=> ext_ack_o.ack)
        else note_failure("debugger TCM access not acknowledged after one cycle");

    // Debugger wins, load/store follows one cycle behind
    a_dtcm_contention: assert property (@(posedge clk_i) disable iff (rst_i)
        $rose(ext_req_i.req) && $rose(lsu_req_i.req) && ext_in_dtcm && lsu_in_dtcm
        |=> ext_ack_o.ack && !lsu_ack_o.ack ##1 lsu_ack_o.ack && !ext_ack_o.ack)
        else note_failure("DTCM contention order or timing wrong");

    a_data_fields: assert property (@(posedge clk_i) disable iff (rst_i)
        lsu_req_i.req && lsu_in_ext |-> data_req_o == lsu_req_i)
        else note_failure("external bus request differs from load/store request");

    a_data_idle: assert property (@(posedge clk_i) disable iff (rst_i)
        !(lsu_req_i.req && lsu_in_ext) |-> !data_req_o.req)
        else note_failure("external bus request without a matching load/store");

    a_data_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        data_req_o.req && !data_ack_i.ack |=> $stable(data_req_o))
        else note_failure("external bus request changed before its ack");

    a_data_ack_pass: assert property (@(posedge clk_i) disable iff (rst_i)
        data_ack_i.ack |-> lsu_ack_o.ack && lsu_ack_o.rdata == data_ack_i.rdata
            && lsu_ack_o.error == data_ack_i.error)
        else note_failure("slave response not passed to load/store port");

    a_lsu_err_latency: assert property (@(posedge clk_i) disable iff (rst_i)
        $rose(lsu_req_i.req) && lsu_out |=> lsu_ack_o.ack && lsu_ack_o.error)
        else note_failure("out of window load/store missing error ack");

    a_ext_err_latency: assert property (@(posedge clk_i) disable iff (rst_i)
        $rose(ext_req_i.req) && ext_out |=> ext_ack_o.ack && ext_ack_o.error)
        else note_failure("out of window debugger access missing error ack");

    // ------------------------------------------------------------------
    // Run limit
    // ------------------------------------------------------------------
    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: a request was not acknowledged within %0d cycles", MAX_CYCLES);
            $display("Verification failed");
            $finish;
        end
    end

    // ------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------
    initial begin
        logic [XLEN-1:0] a;
        logic [31:0]     r;
        logic [31:0]     s;
        void'($urandom(32'heb78));
        rst_i     = 1'b1;
        started   = 1'b0;
        fetch_i   = '0;
        lsu_req_i = '0;
        ext_req_i = '0;
        lsu_exp   = '0;
        ext_exp   = '0;
        fetch_exp = '0;
        repeat (4) @(posedge clk_i);
        rst_i <= 1'b0;
        repeat (3) @(posedge clk_i);

        // Program load into ITCM, then random fetches
        for (int i = 0; i < 16; i++) begin
            access(1'b1, 1'b1, ITCM_BASE + 4*i, $urandom(), 4'hF);
        end
        for (int i = 0; i < 24; i++) begin
            r = $urandom_range(15, 0);
            fetch_word(ITCM_BASE + (r << 2));
        end

        // DTCM fill, strobed updates, read back on both ports
        for (int i = 0; i < 16; i++) begin
            access(1'b0, 1'b1, DTCM_BASE + 4*i, $urandom(), 4'hF);
        end
        for (int i = 0; i < 24; i++) begin
            r = $urandom_range(15, 0);
            s = $urandom();
            access(1'b0, 1'b1, DTCM_BASE + (r << 2), $urandom(), s[STRB_W-1:0]);
        end
        for (int i = 0; i < 16; i++) begin
            access(1'b0, 1'b0, DTCM_BASE + 4*i, '0, '0);
            access(1'b1, 1'b0, DTCM_BASE + 4*i, '0, '0);
        end

        // Same cycle requests at the DTCM
        for (int i = 0; i < 4; i++) begin
            fork
                access(1'b1, 1'b0, DTCM_BASE + 4*i, '0, '0);
                access(1'b0, 1'b0, DTCM_BASE + 4*(i + 8), '0, '0);
            join
        end

        // External data window, first address lands in the error hole
        for (int i = 0; i < 8; i++) begin
            a = EXT_DATA_BASE + ($urandom() & 32'h0000_FFFC);
            if (i == 0) begin
                a[15:12] = 4'hF;
            end
            s = $urandom();
            access(1'b0, 1'b1, a, $urandom(), s[STRB_W-1:0]);
            access(1'b0, 1'b0, a, '0, '0);
        end

        // Unmapped addresses, then the shadowed words again
        access(1'b0, 1'b1, ITCM_BASE + 4, $urandom(), 4'hF);
        access(1'b0, 1'b1, DTCM_BASE + DTCM_SIZE, $urandom(), 4'hF);
        access(1'b0, 1'b0, 32'h2000_0000, '0, '0);
        access(1'b1, 1'b1, DTCM_BASE + DTCM_SIZE, $urandom(), 4'hF);
        access(1'b1, 1'b1, EXT_DATA_BASE, $urandom(), 4'hF);
        access(1'b1, 1'b0, ITCM_BASE + 4, '0, '0);
        for (int i = 0; i < 4; i++) begin
            access(1'b0, 1'b0, DTCM_BASE + 4*i, '0, '0);
        end

        repeat (2) @(posedge clk_i);
        $display("Run complete with %0d error(s)", errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* all.f */
design/tcm_pkg.sv
design/tcm_bank.sv
design/tcm_arbiter.sv
design/port_demux.sv
design/tcm_subsystem.sv
dv/tcm_subsystem_tb.sv

/* run.sh */
#!/bin/sh
# Build and run with Verilator, then decide on the log contents
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tcm_subsystem_tb -f all.f -o tcm_sim \
    && ./obj_dir/tcm_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Verification failed" sim.log && exit 1 || exit 0
